// ==== design/cmac_ctl_pkg.sv ====
// link control types
`default_nettype none

package cmac_ctl_pkg;

    // bring-up steps, shared by the receive and transmit machines
    typedef enum logic [1:0] {
        link_idle,
        link_gt_locked,
        link_wait_aligned,
        link_pkt_transfer
    } link_state_t;

    // receive control towards the MAC
    typedef struct packed {
        logic enable;
    } cmac_rx_ctl_t;

    // transmit control towards the MAC
    typedef struct packed {
        logic enable;
        logic send_lfi;
        logic send_rfi;
    } cmac_tx_ctl_t;

endpackage

`default_nettype wire

// ==== design/cmac_stat_pkg.sv ====
// statistics types
`default_nettype none

package cmac_stat_pkg;

    typedef logic [6:0]  rx_total_bytes_t;
    typedef logic [5:0]  tx_total_bytes_t;
    typedef logic [13:0] good_bytes_t;
    typedef logic [2:0]  rx_pkts_t;
    // bad_code and bad_fcs
    typedef logic [2:0]  code_err_t;

    // per-cycle receive outputs of the MAC
    typedef struct packed {
        rx_total_bytes_t total_bytes;
        good_bytes_t     good_bytes;
        logic            good_packets;
        rx_pkts_t        total_packets;
        logic            aligned_err;
        code_err_t       bad_code;
        code_err_t       bad_fcs;
        logic            bad_preamble;
        logic            bad_sfd;
    } cmac_rx_stat_t;

    // per-cycle transmit outputs of the MAC
    typedef struct packed {
        tx_total_bytes_t total_bytes;
        good_bytes_t     good_bytes;
        logic            good_packets;
        logic            total_packets;
        logic            ovf;
        logic            unf;
    } cmac_tx_stat_t;

    // value is the counter index
    typedef enum logic [3:0] {
        sel_rx_good_pkts,
        sel_rx_total_pkts,
        sel_rx_good_bytes,
        sel_rx_total_bytes,
        sel_tx_good_pkts,
        sel_tx_total_pkts,
        sel_tx_good_bytes,
        sel_tx_total_bytes,
        sel_align_err,
        sel_code_err,
        sel_fcs_err,
        sel_preamble_err,
        sel_sfd_err,
        sel_tx_ovf,
        sel_tx_unf
    } stat_sel_t;

    localparam int NUM_STAT = 15;

    // one increment per counter, first field is counter 0
    typedef struct packed {
        good_bytes_t rx_good_pkts;
        good_bytes_t rx_total_pkts;
        good_bytes_t rx_good_bytes;
        good_bytes_t rx_total_bytes;
        good_bytes_t tx_good_pkts;
        good_bytes_t tx_total_pkts;
        good_bytes_t tx_good_bytes;
        good_bytes_t tx_total_bytes;
        good_bytes_t align_err;
        good_bytes_t code_err;
        good_bytes_t fcs_err;
        good_bytes_t preamble_err;
        good_bytes_t sfd_err;
        good_bytes_t tx_ovf;
        good_bytes_t tx_unf;
    } stat_incr_t;

endpackage

`default_nettype wire

// ==== design/cmac_link_fsm.sv ====
// link bring-up state machines
`timescale 1ns/100ps
`default_nettype none

module cmac_link_fsm
    import cmac_ctl_pkg::*;
(
    input  logic         gt_txusrclk2,
    input  logic         usr_rx_reset_w,
    input  logic         stat_rx_aligned,
    output cmac_rx_ctl_t rx_ctl,
    output cmac_tx_ctl_t tx_ctl
);

    link_state_t rx_state;
    link_state_t tx_state;
    logic        reset_done;
    logic        aligned_1d;

    // common to both machines
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            reset_done <= 1'b0;
            aligned_1d <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            aligned_1d <= stat_rx_aligned;
        end
    end

    // receiver stays enabled from gt_locked on
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_state <= link_idle;
            rx_ctl   <= '0;
        end else begin
            case (rx_state)
                link_idle: begin
                    rx_ctl.enable <= 1'b0;
                    if (reset_done) begin
                        rx_state <= link_gt_locked;
                    end
                end
                link_gt_locked: begin
                    rx_ctl.enable <= 1'b1;
                    rx_state      <= link_wait_aligned;
                end
                link_wait_aligned: begin
                    if (aligned_1d) begin
                        rx_state <= link_pkt_transfer;
                    end
                end
                link_pkt_transfer: begin
                    if (!aligned_1d) begin
                        rx_state <= link_idle;
                    end
                end
            endcase
        end
    end

    // faults go out until the receiver is aligned
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_state <= link_idle;
            tx_ctl   <= '0;
        end else begin
            case (tx_state)
                link_idle: begin
                    tx_ctl <= '0;
                    if (reset_done) begin
                        tx_state <= link_gt_locked;
                    end
                end
                link_gt_locked: begin
                    tx_ctl.enable   <= 1'b0;
                    tx_ctl.send_lfi <= 1'b1;
                    tx_ctl.send_rfi <= 1'b1;
                    tx_state        <= link_wait_aligned;
                end
                link_wait_aligned: begin
                    if (aligned_1d) begin
                        tx_state <= link_pkt_transfer;
                    end
                end
                link_pkt_transfer: begin
                    tx_ctl.enable   <= 1'b1;
                    tx_ctl.send_lfi <= 1'b0;
                    tx_ctl.send_rfi <= 1'b0;
                    if (!aligned_1d) begin
                        tx_state <= link_idle;
                    end
                end
            endcase
        end
    end

    // data goes out only with the receiver up and no local fault signalled
    a_tx_needs_rx: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        tx_ctl.enable |-> (rx_ctl.enable && !tx_ctl.send_lfi));

endmodule

`default_nettype wire

// ==== design/cmac_stat_decode.sv ====
// statistics decode
`timescale 1ns/100ps
`default_nettype none

module cmac_stat_decode
    import cmac_stat_pkg::*;
(
    input  logic          gt_txusrclk2,
    input  logic          usr_rx_reset_w,
    input  cmac_rx_stat_t rx_stat,
    input  cmac_tx_stat_t tx_stat,
    output stat_incr_t    incr
);

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            incr <= '0;
        end else begin
            // volume fields, zero extended
            incr.rx_good_pkts   <= good_bytes_t'(rx_stat.good_packets);
            incr.rx_total_pkts  <= good_bytes_t'(rx_stat.total_packets);
            incr.rx_good_bytes  <= rx_stat.good_bytes;
            incr.rx_total_bytes <= good_bytes_t'(rx_stat.total_bytes);
            incr.tx_good_pkts   <= good_bytes_t'(tx_stat.good_packets);
            incr.tx_total_pkts  <= good_bytes_t'(tx_stat.total_packets);
            incr.tx_good_bytes  <= tx_stat.good_bytes;
            incr.tx_total_bytes <= good_bytes_t'(tx_stat.total_bytes);

            // errors count one per cycle however many lanes flag them
            incr.align_err      <= good_bytes_t'(rx_stat.aligned_err);
            incr.code_err       <= good_bytes_t'(|rx_stat.bad_code);
            incr.fcs_err        <= good_bytes_t'(|rx_stat.bad_fcs);
            incr.preamble_err   <= good_bytes_t'(rx_stat.bad_preamble);
            incr.sfd_err        <= good_bytes_t'(rx_stat.bad_sfd);
            incr.tx_ovf         <= good_bytes_t'(tx_stat.ovf);
            incr.tx_unf         <= good_bytes_t'(tx_stat.unf);
        end
    end

endmodule

`default_nettype wire

// ==== design/cmac_stat_accum.sv ====
// statistics counter bank
`timescale 1ns/100ps
`default_nettype none

module cmac_stat_accum
    import cmac_stat_pkg::*;
#(
    parameter int CNT_W = 32
) (
    input  logic                           gt_txusrclk2,
    input  logic                           usr_rx_reset_w,
    input  stat_incr_t                     incr,
    output logic [NUM_STAT-1:0][CNT_W-1:0] counters
);

    good_bytes_t [NUM_STAT-1:0] incr_a;

    // flat view of the increments
    assign incr_a = incr;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            counters <= '0;
        end else begin
            for (int i = 0; i < NUM_STAT; i++) begin
                // first struct field sits at the top of the flat view
                counters[i] <= counters[i] + CNT_W'(incr_a[NUM_STAT-1-i]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/cmac_stat_readout.sv ====
// statistics readout port
`timescale 1ns/100ps
`default_nettype none

module cmac_stat_readout
    import cmac_stat_pkg::*;
#(
    parameter int CNT_W = 32
) (
    input  logic                           gt_txusrclk2,
    input  logic                           usr_rx_reset_w,
    input  logic [NUM_STAT-1:0][CNT_W-1:0] counters,
    input  logic                           rd_req,
    input  stat_sel_t                      rd_sel,
    output logic                           rd_ack,
    output logic [CNT_W-1:0]               rd_data
);

    typedef enum logic [1:0] {
        rd_idle,
        rd_hold,
        rd_release
    } rd_state_t;

    rd_state_t rd_state;

    // four-phase req/ack sequencing
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (rd_req) begin
                        rd_state <= rd_hold;
                    end
                end
                rd_hold: begin
                    if (!rd_req) begin
                        rd_state <= rd_release;
                    end
                end
                // ack is low here for at least one cycle
                rd_release: begin
                    rd_state <= rd_idle;
                end
                default: begin
                    rd_state <= rd_idle;
                end
            endcase
        end
    end

    // snapshot taken on the way into rd_hold
    always_ff @(posedge gt_txusrclk2) begin
        if (rd_state == rd_idle && rd_req) begin
            rd_data <= counters[rd_sel];
        end
    end

    assign rd_ack = (rd_state == rd_hold);

    // reader keeps the request up until it has seen the ack
    a_ack_needs_req: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        $rose(rd_ack) |-> rd_req);

endmodule

`default_nettype wire

// ==== design/cmac_link_ctl.sv ====
// link control and statistics top
`timescale 1ns/100ps
`default_nettype none

module cmac_link_ctl
    import cmac_ctl_pkg::*;
    import cmac_stat_pkg::*;
#(
    parameter int CNT_W = 32
) (
    input  logic             gt_txusrclk2,
    input  logic             usr_rx_reset_w,
    input  logic             stat_rx_aligned,
    input  cmac_rx_stat_t    rx_stat,
    input  cmac_tx_stat_t    tx_stat,
    input  logic             rd_req,
    input  stat_sel_t        rd_sel,
    output cmac_rx_ctl_t     rx_ctl,
    output cmac_tx_ctl_t     tx_ctl,
    output logic             rd_ack,
    output logic [CNT_W-1:0] rd_data
);

    stat_incr_t                     incr;
    logic [NUM_STAT-1:0][CNT_W-1:0] counters;

    cmac_link_fsm link_fsm_i (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .rx_ctl          (rx_ctl),
        .tx_ctl          (tx_ctl)
    );

    // decode, accumulate, readout
    cmac_stat_decode decode_i (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .rx_stat        (rx_stat),
        .tx_stat        (tx_stat),
        .incr           (incr)
    );

    cmac_stat_accum #(
        .CNT_W (CNT_W)
    ) accum_i (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .incr           (incr),
        .counters       (counters)
    );

    cmac_stat_readout #(
        .CNT_W (CNT_W)
    ) readout_i (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .counters       (counters),
        .rd_req         (rd_req),
        .rd_sel         (rd_sel),
        .rd_ack         (rd_ack),
        .rd_data        (rd_data)
    );

endmodule

`default_nettype wire

// ==== sim/cmac_link_ctl_tb.sv ====
// link control testbench
`timescale 1ns/100ps
`default_nettype none

module cmac_link_ctl_tb
    import cmac_ctl_pkg::*;
    import cmac_stat_pkg::*;
();

    localparam int CNT_W       = 16;
    localparam int RAND_CYCLES = 300;
    localparam int HOLD_CYCLES = 40;
    localparam int READ_CYCLES = 8;
    localparam int NUM_READS   = 2 * NUM_STAT + 2;
    localparam int STIM_CYCLES = 30 + RAND_CYCLES + HOLD_CYCLES + 10 + NUM_READS * READ_CYCLES;

    logic             gt_txusrclk2 = 1'b0;
    logic             usr_rx_reset_w;
    logic             stat_rx_aligned;
    cmac_rx_stat_t    rx_stat;
    cmac_tx_stat_t    tx_stat;
    logic             rd_req;
    stat_sel_t        rd_sel;
    cmac_rx_ctl_t     rx_ctl;
    cmac_tx_ctl_t     tx_ctl;
    logic             rd_ack;
    logic [CNT_W-1:0] rd_data;

    logic [31:0]      rng_state = 32'd23;
    logic [CNT_W-1:0] exp_data;
    stat_sel_t        cur_sel;
    logic             armed;
    cmac_rx_stat_t    rx_hist[$];
    cmac_tx_stat_t    tx_hist[$];

    cmac_link_ctl #(
        .CNT_W (CNT_W)
    ) dut_i (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .rx_stat         (rx_stat),
        .tx_stat         (tx_stat),
        .rd_req          (rd_req),
        .rd_sel          (rd_sel),
        .rx_ctl          (rx_ctl),
        .tx_ctl          (tx_ctl),
        .rd_ack          (rd_ack),
        .rd_data         (rd_data)
    );

    always #50 gt_txusrclk2 = ~gt_txusrclk2;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // per-cycle increment of one counter from the raw MAC outputs
    function automatic logic [CNT_W-1:0] stat_increment(input stat_sel_t sel,
                                                        input cmac_rx_stat_t rx,
                                                        input cmac_tx_stat_t tx);
        case (sel)
            sel_rx_good_pkts:   return CNT_W'(rx.good_packets);
            sel_rx_total_pkts:  return CNT_W'(rx.total_packets);
            sel_rx_good_bytes:  return CNT_W'(rx.good_bytes);
            sel_rx_total_bytes: return CNT_W'(rx.total_bytes);
            sel_tx_good_pkts:   return CNT_W'(tx.good_packets);
            sel_tx_total_pkts:  return CNT_W'(tx.total_packets);
            sel_tx_good_bytes:  return CNT_W'(tx.good_bytes);
            sel_tx_total_bytes: return CNT_W'(tx.total_bytes);
            sel_align_err:      return CNT_W'(rx.aligned_err);
            sel_code_err:       return CNT_W'(rx.bad_code != 3'd0);
            sel_fcs_err:        return CNT_W'(rx.bad_fcs != 3'd0);
            sel_preamble_err:   return CNT_W'(rx.bad_preamble);
            sel_sfd_err:        return CNT_W'(rx.bad_sfd);
            sel_tx_ovf:         return CNT_W'(tx.ovf);
            sel_tx_unf:         return CNT_W'(tx.unf);
            default:            return '0;
        endcase
    endfunction

    // sum over everything applied so far, wraps at CNT_W bits
    function automatic logic [CNT_W-1:0] expected_count(input stat_sel_t sel);
        logic [CNT_W-1:0] sum;
        sum = '0;
        foreach (rx_hist[i]) begin
            sum = sum + stat_increment(sel, rx_hist[i], tx_hist[i]);
        end
        return sum;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_stats(input int cycles);
        logic [31:0]   r0;
        logic [31:0]   r1;
        logic [31:0]   r2;
        cmac_rx_stat_t rx;
        cmac_tx_stat_t tx;
        for (int c = 0; c < cycles; c++) begin
            rng_state = xorshift32(rng_state);
            r0 = rng_state;
            rng_state = xorshift32(rng_state);
            r1 = rng_state;
            rng_state = xorshift32(rng_state);
            r2 = rng_state;
            rx = {r0, r1[1:0]};
            tx = r2[23:0];
            @(posedge gt_txusrclk2);
            rx_stat <= rx;
            tx_stat <= tx;
            rx_hist.push_back(rx);
            tx_hist.push_back(tx);
        end
        @(posedge gt_txusrclk2);
        rx_stat <= '0;
        tx_stat <= '0;
        // let the decode and accumulate stages drain
        repeat (4) @(posedge gt_txusrclk2);
    endtask

    task automatic request_counter(input stat_sel_t sel);
        cur_sel = sel;
        exp_data = expected_count(sel);
        @(posedge gt_txusrclk2);
        rd_sel <= sel;
        rd_req <= 1'b1;
        @(negedge gt_txusrclk2);
        while (!rd_ack) begin
            @(negedge gt_txusrclk2);
        end
    endtask

    task automatic release_counter();
        @(posedge gt_txusrclk2);
        rd_req <= 1'b0;
        @(negedge gt_txusrclk2);
        while (rd_ack) begin
            @(negedge gt_txusrclk2);
        end
    endtask

    task automatic read_counter(input stat_sel_t sel);
        request_counter(sel);
        release_counter();
    endtask

    // rd_data must match the snapshot for as long as ack is up
    always @(negedge gt_txusrclk2) begin
        if (rd_ack) begin
            check_value(32'(rd_data), 32'(exp_data), $sformatf("rd_data for %s", cur_sel.name()));
        end
    end

    initial begin
        repeat (STIM_CYCLES + 200) begin
            @(posedge gt_txusrclk2);
        end
        $display("Timeout: the run did not finish within %0d clock cycles", STIM_CYCLES + 200);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        usr_rx_reset_w  = 1'b1;
        stat_rx_aligned = 1'b0;
        rx_stat         = '0;
        tx_stat         = '0;
        rd_req          = 1'b0;
        rd_sel          = sel_rx_good_pkts;
        exp_data        = '0;
        cur_sel         = sel_rx_good_pkts;
        armed           = 1'b0;
        repeat (3) @(posedge gt_txusrclk2);
        usr_rx_reset_w <= 1'b0;

        @(negedge gt_txusrclk2);
        check_value(32'(rx_ctl.enable), 32'd0, "rx_ctl after reset");
        check_value(32'({tx_ctl.enable, tx_ctl.send_lfi, tx_ctl.send_rfi}), 32'd0,
                    "tx_ctl after reset");
        check_value(32'(rd_ack), 32'd0, "rd_ack after reset");

        // bring-up lands on the third edge after reset release
        repeat (2) @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_value(32'(rx_ctl.enable), 32'd0, "rx_ctl.enable two edges after reset");
        @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_value(32'(rx_ctl.enable), 32'd1, "rx_ctl.enable three edges after reset");
        check_value(32'({tx_ctl.enable, tx_ctl.send_lfi, tx_ctl.send_rfi}), 32'b011,
                    "tx_ctl before alignment");

        for (int i = 0; i < NUM_STAT; i++) begin
            read_counter(stat_sel_t'(i));
        end

        @(posedge gt_txusrclk2);
        stat_rx_aligned <= 1'b1;
        repeat (2) @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_value(32'(tx_ctl.enable), 32'd0, "tx_ctl.enable two edges after alignment");
        @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_value(32'({tx_ctl.enable, tx_ctl.send_lfi, tx_ctl.send_rfi}), 32'b100,
                    "tx_ctl three edges after alignment");

        @(posedge gt_txusrclk2);
        stat_rx_aligned <= 1'b0;
        repeat (3) @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_value(32'(tx_ctl.enable), 32'd0, "tx_ctl.enable after alignment loss");
        check_value(32'(rx_ctl.enable), 32'd0, "rx_ctl.enable after alignment loss");
        for (int i = 0; i < 8 && !armed; i++) begin
            @(negedge gt_txusrclk2);
            armed = rx_ctl.enable && tx_ctl.send_lfi && tx_ctl.send_rfi;
        end
        if (!armed) begin
            $display("The link state machines did not re-arm after alignment was lost");
            $display("Simulation failed");
            $fatal(1, "no re-arm");
        end
        check_value(32'(tx_ctl.enable), 32'd0, "tx_ctl.enable after re-arm");

        drive_stats(RAND_CYCLES);
        for (int i = 0; i < NUM_STAT; i++) begin
            read_counter(stat_sel_t'(i));
        end

        // hold the request while new statistics keep arriving
        request_counter(sel_rx_good_bytes);
        drive_stats(HOLD_CYCLES);
        @(negedge gt_txusrclk2);
        check_value(32'(rd_ack), 32'd1, "rd_ack while rd_req is held");
        release_counter();
        read_counter(sel_rx_good_bytes);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cmac_link_ctl.f ====
design/cmac_ctl_pkg.sv
design/cmac_stat_pkg.sv
design/cmac_link_fsm.sv
design/cmac_stat_decode.sv
design/cmac_stat_accum.sv
design/cmac_stat_readout.sv
design/cmac_link_ctl.sv
sim/cmac_link_ctl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module cmac_link_ctl_tb -f cmac_link_ctl.f \
    && ./obj_dir/Vcmac_link_ctl_tb \
    || exit 1
